//--- ddr4MonitorPatterns.hex
// ctrl(valid,memResetN,csN,actN) adr ba bg | expected cmd colAdr rankAdr0 rankAdr1
// rankBa0 rankBa1 rankBg0 rankBg1 wrDir; rank 1 is mirrored
// An all-zero line ends the list
F_12345_1_2_0_12345_12345_10AA5_1_2_2_1_0
C_0E52C_2_1_1_0E52C_0E52C_0CCD4_2_1_1_2_0
D_00123_0_0_2_00123_00123_000C3_0_0_0_0_0
D_04010_3_3_3_04010_04010_04008_3_3_3_3_0
D_06000_2_2_3_06000_06000_04800_2_1_2_1_0
D_0BC40_1_0_4_0BC40_0BC40_0BC20_1_2_0_0_0
D_08150_1_1_4_08150_08150_080A8_1_2_1_2_0
D_138A9_2_3_5_100A9_100A9_10151_2_1_3_3_1
D_1C208_0_1_8_1C208_1C208_1C210_0_0_1_2_1
C_00801_0_0_1_00801_00801_02001_0_0_0_0_1
F_14000_0_0_0_14000_14000_14000_0_0_0_0_1
D_17FFF_1_2_6_147FF_147FF_147FF_1_2_2_1_0
D_18468_3_0_7_18468_18468_18470_3_3_0_0_0
D_0C000_0_0_9_0C000_0C000_0C000_0_0_0_0_0
D_12804_0_0_5_10004_10004_10004_0_0_0_0_1
9_1C000_0_0_8_1C000_1C000_1C000_0_0_0_0_0
9_10000_0_0_5_10000_10000_10000_0_0_0_0_0
D_12A55_1_2_5_10255_10255_1022D_1_2_2_1_1
D_16190_2_1_6_14190_14190_14188_2_1_1_2_0
D_10000_0_0_5_10000_10000_10000_0_0_0_0_1
B_00000_0_0_0_00000_00000_00000_0_0_0_0_0
D_1C000_0_0_8_1C000_1C000_1C000_0_0_0_0_0
0_00000_0_0_0_00000_00000_00000_0_0_0_0_0

//--- ddr4CmdMonitor.f
+incdir+.
ddr4BusPkg.sv
ddr4CmdPkg.sv
ddr4CmdDecode.sv
ddr4RankDrive.sv
ddr4CmdMonitor.sv
tbDdr4CmdMonitor.sv

//--- Makefile
# Verilator build and run for the DDR4 command monitor

VERILATOR ?= verilator
TOP       ?= tbDdr4CmdMonitor
FILELIST  ?= ddr4CmdMonitor.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --binary --timing -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -f $(FILELIST)
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "STATUS: FAIL" $(LOG); then exit 1; fi; exit $$status

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- tbDdr4CmdMonitor.sv
`include "ddr4Monitor_macros.svh"

module tbDdr4CmdMonitor
    import ddr4BusPkg::*;
    import ddr4CmdPkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam time clkPeriod    = 100ns;
    localparam time driveDelay   = 1ns;
    localparam int  resetCycles  = 4;
    localparam int  resetTimeout = 20;
    localparam int  maxVectors   = 64;
    localparam int  vecWidth     = 116;

    logic         c0_ddr4_ck_t;
    logic         arstN;
    logic         memResetN;
    ddr4Cs_t      csN;
    logic         actN;
    ddr4Adr_t     adr;
    ddr4Ba_t      ba;
    ddr4Bg_t      bg;
    ddr4Cmd_t     cmd;
    ddr4Adr_t     colAdr;
    ddr4AdrRank_t rankAdr;
    ddr4BaRank_t  rankBa;
    ddr4BgRank_t  rankBg;
    logic         wrDir;

    // Top nibble holds valid, memResetN, csN, actN
    logic [vecWidth-1:0] vectors [0:maxVectors-1];
    int numVectors;
    int errors;
    int checks;

    ddr4CmdMonitor ddr4CmdMonitor_i (
        .c0_ddr4_ck_t (c0_ddr4_ck_t),
        .arstN        (arstN),
        .memResetN    (memResetN),
        .csN          (csN),
        .actN         (actN),
        .adr          (adr),
        .ba           (ba),
        .bg           (bg),
        .cmd          (cmd),
        .colAdr       (colAdr),
        .rankAdr      (rankAdr),
        .rankBa       (rankBa),
        .rankBg       (rankBg),
        .wrDir        (wrDir)
    );

    //////////////////////////////
    // Clock and reset
    //////////////////////////////

    initial c0_ddr4_ck_t = 1'b0;
    always #(clkPeriod / 2) c0_ddr4_ck_t = ~c0_ddr4_ck_t;

    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge c0_ddr4_ck_t);
        #(driveDelay);
        arstN = 1'b1;
    end

    //////////////////////////////
    // Compare tasks
    //////////////////////////////

    task automatic checkCmd(input string name, input ddr4Cmd_t expected,
                            input ddr4Cmd_t actual, input string where);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected 0x%h, actual 0x%h at %s", name, expected, actual, where);
        end
    endtask

    task automatic checkAdr(input string name, input ddr4Adr_t expected,
                            input ddr4Adr_t actual, input string where);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected 0x%h, actual 0x%h at %s", name, expected, actual, where);
        end
    endtask

    task automatic checkRank(input ddr4AdrRank_t expAdr, input ddr4AdrRank_t actAdr,
                             input ddr4BaRank_t expBa, input ddr4BaRank_t actBa,
                             input ddr4BgRank_t expBg, input ddr4BgRank_t actBg,
                             input string where);
        for (int r = 0; r < `DDR4_RANKS; r++) begin
            checks++;
            if (actAdr[r] !== expAdr[r]) begin
                errors++;
                $display("ERROR rankAdr[%0d]: expected 0x%h, actual 0x%h at %s",
                         r, expAdr[r], actAdr[r], where);
            end
            if (actBa[r] !== expBa[r]) begin
                errors++;
                $display("ERROR rankBa[%0d]: expected 0x%h, actual 0x%h at %s",
                         r, expBa[r], actBa[r], where);
            end
            if (actBg[r] !== expBg[r]) begin
                errors++;
                $display("ERROR rankBg[%0d]: expected 0x%h, actual 0x%h at %s",
                         r, expBg[r], actBg[r], where);
            end
        end
    endtask

    task automatic checkFlag(input string name, input logic expected,
                             input logic actual, input string where);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: expected 0x%h, actual 0x%h at %s", name, expected, actual, where);
        end
    endtask

    //////////////////////////////
    // Stimulus helpers
    //////////////////////////////

    // Bus deselected, DRAM out of reset
    task automatic driveIdle();
        memResetN = 1'b1;
        csN       = '1;
        actN      = 1'b1;
        adr       = '0;
        ba        = '0;
        bg        = '0;
    endtask

    task automatic applyVector(input logic [vecWidth-1:0] v);
        memResetN = v[114];
        csN       = {`DDR4_CS_WIDTH{v[113]}};
        actN      = v[112];
        adr       = v[108:92];
        ba        = v[89:88];
        bg        = v[85:84];
    endtask

    task automatic compareOutputs(input logic [vecWidth-1:0] v, input string where);
        ddr4AdrRank_t expAdr;
        ddr4BaRank_t  expBa;
        ddr4BgRank_t  expBg;
        expAdr[0] = v[56:40];
        expAdr[1] = v[36:20];
        expBa[0]  = v[17:16];
        expBa[1]  = v[13:12];
        expBg[0]  = v[9:8];
        expBg[1]  = v[5:4];
        checkCmd("cmd", ddr4Cmd_t'(v[83:80]), cmd, where);
        checkAdr("colAdr", v[76:60], colAdr, where);
        checkRank(expAdr, rankAdr, expBa, rankBa, expBg, rankBg, where);
        checkFlag("wrDir", v[0], wrDir, where);
    endtask

    // Returns as soon as arstN rises, before the next clock edge
    task automatic waitForReset(output bit released);
        int cycles;
        cycles = 0;
        while ((arstN !== 1'b1) && (cycles < resetTimeout)) begin
            @(posedge c0_ddr4_ck_t or posedge arstN);
            cycles++;
        end
        released = (arstN === 1'b1);
    endtask

    task automatic finishRun();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    endtask

    //////////////////////////////
    // Pattern replay
    //////////////////////////////

    initial begin
        bit released;
        errors     = 0;
        checks     = 0;
        numVectors = 0;
        driveIdle();
        $readmemh("ddr4MonitorPatterns.hex", vectors);
        // All-zero line ends the list
        while ((numVectors < maxVectors) && (vectors[numVectors][vecWidth-1] === 1'b1)) begin
            numVectors++;
        end
        if (numVectors == 0) begin
            errors++;
            $display("No vectors were found in the pattern file");
        end
        waitForReset(released);
        if (!released) begin
            errors++;
            $display("Reset was not released within %0d cycles", resetTimeout);
            finishRun();
        end else begin
            // Reset values, no edge has sampled the bus yet
            checkCmd("cmd", cmdDsel, cmd, "after reset");
            checkFlag("wrDir", 1'b0, wrDir, "after reset");
            if (numVectors > 0) begin
                applyVector(vectors[0]);
            end
            // Vector i is checked one edge after it is applied
            for (int i = 0; i < numVectors; i++) begin
                @(posedge c0_ddr4_ck_t);
                #(driveDelay);
                compareOutputs(vectors[i], $sformatf("vector %0d", i));
                if (i + 1 < numVectors) begin
                    applyVector(vectors[i + 1]);
                end else begin
                    driveIdle();
                end
            end
            finishRun();
        end
    end

endmodule

//--- ddr4CmdMonitor.sv
`include "ddr4Monitor_macros.svh"

module ddr4CmdMonitor
    import ddr4BusPkg::*;
    import ddr4CmdPkg::*;
(
    input  logic         c0_ddr4_ck_t,
    input  logic         arstN,
    input  logic         memResetN,
    input  ddr4Cs_t      csN,
    input  logic         actN,
    input  ddr4Adr_t     adr,
    input  ddr4Ba_t      ba,
    input  ddr4Bg_t      bg,
    output ddr4Cmd_t     cmd,
    output ddr4Adr_t     colAdr,
    output ddr4AdrRank_t rankAdr,
    output ddr4BaRank_t  rankBa,
    output ddr4BgRank_t  rankBg,
    output logic         wrDir
);

    logic colCmd;

    //////////////////////////////
    // Command decode
    //////////////////////////////

    ddr4CmdDecode ddr4CmdDecode_i (
        .c0_ddr4_ck_t (c0_ddr4_ck_t),
        .arstN        (arstN),
        .memResetN    (memResetN),
        .csN          (csN),
        .actN         (actN),
        .adr          (adr),
        .cmd          (cmd),
        .colCmd       (colCmd),
        .colAdr       (colAdr),
        .wrDir        (wrDir)
    );

    //////////////////////////////
    // Rank copies
    //////////////////////////////

    // Rank 1 is mirrored
    ddr4RankDrive #(
        .mirrorOn (1)
    ) ddr4RankDrive_i (
        .c0_ddr4_ck_t (c0_ddr4_ck_t),
        .arstN        (arstN),
        .colCmd       (colCmd),
        .adr          (adr),
        .ba           (ba),
        .bg           (bg),
        .rankAdr      (rankAdr),
        .rankBa       (rankBa),
        .rankBg       (rankBg)
    );

endmodule

//--- ddr4RankDrive.sv
`include "ddr4Monitor_macros.svh"

module ddr4RankDrive
    import ddr4BusPkg::*;
#(
    parameter int mirrorOn = 0
) (
    input  logic         c0_ddr4_ck_t,
    input  logic         arstN,
    input  logic         colCmd,
    input  ddr4Adr_t     adr,
    input  ddr4Ba_t      ba,
    input  ddr4Bg_t      bg,
    output ddr4AdrRank_t rankAdr,
    output ddr4BaRank_t  rankBa,
    output ddr4BgRank_t  rankBg
);

    ddr4AdrRank_t adrD;
    ddr4AdrRank_t adrQ;
    ddr4BaRank_t  baD;
    ddr4BgRank_t  bgD;

    //////////////////////////////
    // Clamshell mirroring
    //////////////////////////////

    function automatic ddr4Adr_t mirrorAdr(input ddr4Adr_t a);
        ddr4Adr_t m;
        m     = a;
        m[3]  = a[4];
        m[4]  = a[3];
        m[5]  = a[6];
        m[6]  = a[5];
        m[7]  = a[8];
        m[8]  = a[7];
        m[11] = a[13];
        m[13] = a[11];
        return m;
    endfunction

    // Odd ranks sit on the back side of the module
    always_comb begin
        for (int r = 0; r < `DDR4_RANKS; r++) begin
            if ((mirrorOn != 0) && (r % 2 == 1)) begin
                adrD[r] = mirrorAdr(adr);
                baD[r]  = {ba[0], ba[1]};
                bgD[r]  = {bg[0], bg[1]};
            end else begin
                adrD[r] = adr;
                baD[r]  = ba;
                bgD[r]  = bg;
            end
        end
    end

    always_ff @(posedge c0_ddr4_ck_t or negedge arstN) begin
        if (!arstN) begin
            adrQ   <= '0;
            rankBa <= '0;
            rankBg <= '0;
        end else begin
            adrQ   <= adrD;
            rankBa <= baD;
            rankBg <= bgD;
        end
    end

    // colCmd is already registered, so mask after the flop
    always_comb begin
        for (int r = 0; r < `DDR4_RANKS; r++) begin
            rankAdr[r] = colCmd ? (adrQ[r] & `DDR4_COL_MASK) : adrQ[r];
        end
    end

endmodule

//--- ddr4CmdDecode.sv
`include "ddr4Monitor_macros.svh"

module ddr4CmdDecode
    import ddr4BusPkg::*;
    import ddr4CmdPkg::*;
(
    input  logic     c0_ddr4_ck_t,
    input  logic     arstN,
    input  logic     memResetN,
    input  ddr4Cs_t  csN,
    input  logic     actN,
    input  ddr4Adr_t adr,
    output ddr4Cmd_t cmd,
    output logic     colCmd,
    output ddr4Adr_t colAdr,
    output logic     wrDir
);

    ddr4Op_t  op;
    ddr4Cmd_t cmdNext;
    logic     colNext;

    //////////////////////////////
    // Command decode
    //////////////////////////////

    assign op = ddr4Op_t'(adr[`DDR4_CMD_MSB:`DDR4_CMD_LSB]);

    always_comb begin
        cmdNext = cmdBad;
        if (&csN) begin
            cmdNext = cmdDsel;
        end else if (!actN) begin
            // Row address sits in A16..A14 here
            cmdNext = cmdAct;
        end else begin
            case (op)
                opMrs:      cmdNext = cmdMrs;
                opRef:      cmdNext = cmdRef;
                opPre:      cmdNext = cmdPre;
                opActField: cmdNext = cmdBad;
                opWr:       cmdNext = cmdWr;
                opRd:       cmdNext = cmdRd;
                opZqc:      cmdNext = cmdZqc;
                opNop:      cmdNext = cmdNop;
            endcase
        end
    end

    assign colNext = (cmdNext == cmdWr) || (cmdNext == cmdRd);

    //////////////////////////////
    // Registered outputs
    //////////////////////////////

    always_ff @(posedge c0_ddr4_ck_t or negedge arstN) begin
        if (!arstN) begin
            cmd    <= cmdDsel;
            colCmd <= 1'b0;
        end else begin
            cmd    <= cmdNext;
            colCmd <= colNext;
        end
    end

    // Burst chop and spare column bits dropped
    always_ff @(posedge c0_ddr4_ck_t) begin
        colAdr <= colNext ? (adr & `DDR4_COL_MASK) : adr;
    end

    // Bus reset wins over the command
    always_ff @(posedge c0_ddr4_ck_t or negedge arstN) begin
        if (!arstN) begin
            wrDir <= 1'b0;
        end else if (!memResetN) begin
            wrDir <= 1'b0;
        end else if (cmdNext == cmdWr) begin
            wrDir <= 1'b1;
        end else if (cmdNext == cmdRd) begin
            wrDir <= 1'b0;
        end
    end

endmodule

//--- ddr4CmdPkg.sv
`include "ddr4Monitor_macros.svh"

package ddr4CmdPkg;

    // Opcode as seen on A16..A14 with ACT_n high
    typedef enum logic [`DDR4_CMD_MSB-`DDR4_CMD_LSB:0] {
        opMrs      = 3'd0,
        opRef      = 3'd1,
        opPre      = 3'd2,
        opActField = 3'd3,
        opWr       = 3'd4,
        opRd       = 3'd5,
        opZqc      = 3'd6,
        opNop      = 3'd7
    } ddr4Op_t;

    // Decoded command, BAD marks an undefined pattern
    typedef enum logic [3:0] {
        cmdDsel,
        cmdAct,
        cmdMrs,
        cmdRef,
        cmdPre,
        cmdWr,
        cmdRd,
        cmdZqc,
        cmdNop,
        cmdBad
    } ddr4Cmd_t;

endpackage

//--- ddr4BusPkg.sv
`include "ddr4Monitor_macros.svh"

package ddr4BusPkg;

    //////////////////////////////
    // Single bus copy
    //////////////////////////////

    typedef logic [`DDR4_ADDR_WIDTH-1:0] ddr4Adr_t;
    typedef logic [1:0] ddr4Ba_t;
    typedef logic [1:0] ddr4Bg_t;

    // One pin per rank pair
    typedef logic [`DDR4_CS_WIDTH-1:0] ddr4Cs_t;

    //////////////////////////////
    // Per-rank copies
    //////////////////////////////

    typedef ddr4Adr_t [`DDR4_RANKS-1:0] ddr4AdrRank_t;
    typedef ddr4Ba_t [`DDR4_RANKS-1:0] ddr4BaRank_t;
    typedef ddr4Bg_t [`DDR4_RANKS-1:0] ddr4BgRank_t;

endpackage

//--- ddr4Monitor_macros.svh
`ifndef DDR4_MONITOR_MACROS_SVH
`define DDR4_MONITOR_MACROS_SVH

//////////////////////////////
// Bus geometry
//////////////////////////////

// x8 parts, A0..A16
`define DDR4_ADDR_WIDTH 17

// Clamshell pair
`define DDR4_RANKS 2
`define DDR4_CS_WIDTH 1

//////////////////////////////
// Command field
//////////////////////////////

// RAS_n/CAS_n/WE_n share A16..A14
`define DDR4_CMD_MSB 16
`define DDR4_CMD_LSB 14

// Clears A13..A11 on WR and RD
`define DDR4_COL_MASK 17'h1C7FF

`endif
